/* list.f */
+incdir+sim
logic/bridgePkg.sv
logic/cycleDecode.sv
logic/requestFifo.sv
logic/pciCycleFsm.sv
logic/cycleTermination.sv
logic/pciBridgeTop.sv
sim/pciBridgeTb.sv

/* logic/bridgePkg.sv */
// Local bus to PCI bridge
// Shared types and constants
package bridgePkg;

    ////////////////////
    // Bus widths
    ////////////////////

    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [3:0]  pciCmdT;
    typedef logic [4:0]  idselT;

    // Queue entry is {cmd, addr, data, idsel}, command in the top bits
    localparam int fifoWordW = $bits(pciCmdT) + $bits(addrT) + $bits(dataT) + $bits(idselT);
    typedef logic [fifoWordW-1:0] fifoWordT;

    ////////////////////
    // PCI commands
    ////////////////////

    localparam pciCmdT cmdMemRead  = 4'h6;
    localparam pciCmdT cmdMemWrite = 4'h7;
    localparam pciCmdT cmdCfgRead  = 4'hA;
    localparam pciCmdT cmdCfgWrite = 4'hB;

    ////////////////////
    // Address map and sizing
    ////////////////////

    // Top nibble C selects config space
    localparam logic [3:0] cfgWindow = 4'hC;
    localparam int slotCount  = 5;
    localparam int fifoDepth  = 4;
    localparam int fifoPtrW   = $clog2(fifoDepth);
    localparam int fifoCntW   = $clog2(fifoDepth + 1);
    // Data phase cycles without DEVSEL before giving up
    localparam int abortLimit = 5;
    localparam int abortCntW  = $clog2(abortLimit);

    // PCI master sequencing
    typedef enum logic [1:0] {stIdle, stAddr, stData, stTurn} pciStateT;

endpackage

/* logic/cycleDecode.sv */
// Request decode
// Sorts CPU requests into memory or config cycles
`timescale 1ns/1ps

module cycleDecode (
    input  logic               CLK40,
    input  logic               rstN,
    input  logic               cpuValid,
    input  logic               cpuRnW,
    input  bridgePkg::addrT    cpuAddr,
    input  bridgePkg::dataT    cpuWrData,
    input  logic               full,
    input  logic               readPending,
    output logic               cpuReady,
    output logic               pushValid,
    output bridgePkg::fifoWordT pushWord,
    output logic               accept,
    output logic               acceptRnW
);
    import bridgePkg::*;

    logic       isCfg;
    logic [2:0] slotNum;
    pciCmdT     decCmd;
    addrT       decAddr;
    idselT      decIdsel;

    ////////////////////
    // Handshake
    ////////////////////

    // No room, read outstanding, or a push still in flight
    // Waiting on the in-flight push keeps full current
    assign cpuReady  = !full && !readPending && !pushValid;
    assign accept    = cpuValid && cpuReady;
    assign acceptRnW = cpuRnW;

    ////////////////////
    // Decode
    ////////////////////

    assign isCfg   = (cpuAddr[31:28] == cfgWindow);
    // Device number field of a type-0 address
    assign slotNum = cpuAddr[13:11];

    always_comb begin
        if (isCfg) begin
            decCmd   = cpuRnW ? cmdCfgRead : cmdCfgWrite;
            // Only the register number survives
            decAddr  = {21'd0, cpuAddr[10:2], 2'b00};
        end else begin
            decCmd   = cpuRnW ? cmdMemRead : cmdMemWrite;
            decAddr  = cpuAddr;
        end
        // One-hot IDSEL, nothing for slots with no socket
        if (isCfg && (slotNum < slotCount)) begin
            decIdsel = idselT'(1) << slotNum;
        end else begin
            decIdsel = '0;
        end
    end

    ////////////////////
    // Push register
    ////////////////////

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            pushValid <= 1'b0;
        end else begin
            pushValid <= accept;
        end
    end

    // Entry payload
    always_ff @(posedge CLK40) begin
        if (accept) begin
            pushWord <= {decCmd, decAddr, cpuWrData, decIdsel};
        end
    end

endmodule

/* logic/cycleTermination.sv */
// Cycle termination
// Acknowledge and read data back to the CPU
`timescale 1ns/1ps

module cycleTermination (
    input  logic            CLK40,
    input  logic            rstN,
    input  logic            accept,
    input  logic            acceptRnW,
    input  logic            readDone,
    input  bridgePkg::dataT readData,
    output logic            readPending,
    output logic            cpuRspValid,
    output bridgePkg::dataT cpuRdData
);

    logic writeAck;
    logic readAck;

    ////////////////////
    // Acknowledge sources
    ////////////////////

    // Posted write, acked straight away
    assign writeAck = accept && !acceptRnW;
    // Read finished on PCI
    assign readAck  = readDone && readPending;

    ////////////////////
    // Pending read and ack pulse
    ////////////////////

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            readPending <= 1'b0;
            cpuRspValid <= 1'b0;
        end else begin
            // Single outstanding read
            if (accept && acceptRnW) begin
                readPending <= 1'b1;
            end else if (readAck) begin
                readPending <= 1'b0;
            end
            cpuRspValid <= writeAck || readAck;
        end
    end

    // Data lines up with the ack pulse
    always_ff @(posedge CLK40) begin
        if (readAck) begin
            cpuRdData <= readData;
        end
    end

endmodule

/* logic/pciBridgeTop.sv */
// Local bus to PCI bridge
`timescale 1ns/1ps

module pciBridgeTop (
    input  logic              CLK40,
    input  logic              rstN,
    input  logic              cpuValid,
    input  logic              cpuRnW,
    input  bridgePkg::addrT   cpuAddr,
    input  bridgePkg::dataT   cpuWrData,
    input  logic              trdyN,
    input  logic              devselN,
    input  bridgePkg::dataT   adIn,
    output logic              cpuReady,
    output logic              cpuRspValid,
    output bridgePkg::dataT   cpuRdData,
    output logic              frameN,
    output logic              irdyN,
    output bridgePkg::pciCmdT cbeN,
    output bridgePkg::dataT   adOut,
    output logic              adOe,
    output bridgePkg::idselT  idsel
);
    import bridgePkg::*;

    // Decode to queue
    logic     pushValid;
    fifoWordT pushWord;
    logic     full;
    // Queue to master
    logic     popReady;
    logic     empty;
    fifoWordT headWord;
    // Termination handshake
    logic     accept;
    logic     acceptRnW;
    logic     readPending;
    logic     readDone;
    dataT     readData;

    ////////////////////
    // CPU side
    ////////////////////

    cycleDecode cycleDecode_i (
        .CLK40(CLK40), .rstN(rstN),
        .cpuValid(cpuValid), .cpuRnW(cpuRnW), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
        .full(full), .readPending(readPending),
        .cpuReady(cpuReady), .pushValid(pushValid), .pushWord(pushWord),
        .accept(accept), .acceptRnW(acceptRnW)
    );

    requestFifo requestFifo_i (
        .CLK40(CLK40), .rstN(rstN),
        .pushValid(pushValid), .pushWord(pushWord), .popReady(popReady),
        .full(full), .empty(empty), .headWord(headWord)
    );

    ////////////////////
    // PCI side
    ////////////////////

    pciCycleFsm pciCycleFsm_i (
        .CLK40(CLK40), .rstN(rstN),
        .empty(empty), .headWord(headWord),
        .trdyN(trdyN), .devselN(devselN), .adIn(adIn),
        .popReady(popReady), .frameN(frameN), .irdyN(irdyN), .cbeN(cbeN),
        .adOut(adOut), .adOe(adOe), .idsel(idsel),
        .readDone(readDone), .readData(readData)
    );

    cycleTermination cycleTermination_i (
        .CLK40(CLK40), .rstN(rstN),
        .accept(accept), .acceptRnW(acceptRnW),
        .readDone(readDone), .readData(readData),
        .readPending(readPending), .cpuRspValid(cpuRspValid), .cpuRdData(cpuRdData)
    );

endmodule

/* logic/pciCycleFsm.sv */
// PCI master
// Runs one transaction at a time from the queue
`timescale 1ns/1ps

module pciCycleFsm (
    input  logic                CLK40,
    input  logic                rstN,
    input  logic                empty,
    input  bridgePkg::fifoWordT headWord,
    input  logic                trdyN,
    input  logic                devselN,
    input  bridgePkg::dataT     adIn,
    output logic                popReady,
    output logic                frameN,
    output logic                irdyN,
    output bridgePkg::pciCmdT   cbeN,
    output bridgePkg::dataT     adOut,
    output logic                adOe,
    output bridgePkg::idselT    idsel,
    output logic                readDone,
    output bridgePkg::dataT     readData
);
    import bridgePkg::*;

    pciStateT             state;
    pciStateT             stateNext;
    pciCmdT               curCmd;
    addrT                 curAddr;
    dataT                 curData;
    idselT                curIdsel;
    logic                 curWrite;
    logic [abortCntW-1:0] abortCnt;
    logic                 claimed;
    logic                 abortHit;
    logic                 dataEnd;

    // Big endian local side against little endian PCI
    function automatic dataT byteSwap(input dataT w);
        byteSwap = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    ////////////////////
    // Sequencing
    ////////////////////

    assign popReady = (state == stIdle) && !empty;
    assign curWrite = (curCmd == cmdMemWrite) || (curCmd == cmdCfgWrite);

    // Target ready with DEVSEL
    assign claimed  = !devselN && !trdyN;
    // Nobody decoded the address in time
    assign abortHit = devselN && (abortCnt == abortCntW'(abortLimit - 1));
    assign dataEnd  = (state == stData) && (claimed || abortHit);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:  if (!empty) stateNext = stAddr;
            stAddr:  stateNext = stData;
            stData:  if (dataEnd) stateNext = stTurn;
            stTurn:  stateNext = stIdle;
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            abortCnt <= '0;
            readDone <= 1'b0;
        end else begin
            state    <= stateNext;
            readDone <= dataEnd && !curWrite;
            if (state == stAddr) begin
                abortCnt <= '0;
            end else if ((state == stData) && devselN && !abortHit) begin
                abortCnt <= abortCnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Transaction payload
    ////////////////////

    // Popped word held until the next pop
    always_ff @(posedge CLK40) begin
        if (popReady) begin
            {curCmd, curAddr, curData, curIdsel} <= headWord;
        end
    end

    // Master abort reads back all ones
    always_ff @(posedge CLK40) begin
        if (dataEnd && !curWrite) begin
            readData <= claimed ? byteSwap(adIn) : '1;
        end
    end

    ////////////////////
    // Bus drive
    ////////////////////

    assign frameN = (state != stAddr);
    assign irdyN  = (state != stData);
    // Write data only, reads leave AD to the target
    assign adOe   = (state == stAddr) || ((state == stData) && curWrite);
    assign idsel  = (state == stAddr) ? curIdsel : '0;

    always_comb begin
        case (state)
            stAddr: begin
                adOut = curAddr;
                cbeN  = curCmd;
            end
            stData: begin
                adOut = byteSwap(curData);
                // All four byte lanes enabled
                cbeN  = 4'b0000;
            end
            default: begin
                adOut = '0;
                cbeN  = 4'b1111;
            end
        endcase
    end

endmodule

/* logic/requestFifo.sv */
// Request queue
// Holds decoded requests so writes can be posted
`timescale 1ns/1ps

module requestFifo (
    input  logic                CLK40,
    input  logic                rstN,
    input  logic                pushValid,
    input  bridgePkg::fifoWordT pushWord,
    input  logic                popReady,
    output logic                full,
    output logic                empty,
    output bridgePkg::fifoWordT headWord
);
    import bridgePkg::*;

    fifoWordT            mem [fifoDepth];
    logic [fifoPtrW-1:0] wrPtr;
    logic [fifoPtrW-1:0] rdPtr;
    logic [fifoCntW-1:0] count;
    logic                doPush;
    logic                doPop;

    ////////////////////
    // Status
    ////////////////////

    assign full     = (count == fifoCntW'(fifoDepth));
    assign empty    = (count == '0);
    // Head always visible to the FSM
    assign headWord = mem[rdPtr];

    // Drop requests that would overrun or underrun
    assign doPush = pushValid && !full;
    assign doPop  = popReady && !empty;

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge CLK40 or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                // Wrap at depth
                if (wrPtr == fifoPtrW'(fifoDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (doPop) begin
                if (rdPtr == fifoPtrW'(fifoDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            // Both at once leaves the count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge CLK40) begin
        if (doPush) begin
            mem[wrPtr] <= pushWord;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the PCI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pciBridgeTb -f list.f -o simBridge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simBridge > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* sim/bridgeCheck.svh */
// Bridge reference model
// Expected values and typed compares
`ifndef BRIDGE_CHECK_SVH
`define BRIDGE_CHECK_SVH

////////////////////
// Reference functions
////////////////////

// Local big endian word as it appears on AD
function automatic dataT swapBytes(input dataT w);
    dataT r;
    for (int i = 0; i < 4; i++) begin
        r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
endfunction

// Memory 6/7, config A/B
function automatic pciCmdT expectCmd(input logic isRead, input addrT a);
    if (a[31:28] == 4'hC) begin
        return isRead ? 4'hA : 4'hB;
    end
    return isRead ? 4'h6 : 4'h7;
endfunction

// Five sockets, device field picks the line
function automatic idselT expectIdsel(input addrT a);
    if (a[31:28] != 4'hC) begin
        return 5'b00000;
    end
    case (a[13:11])
        3'd0:    return 5'b00001;
        3'd1:    return 5'b00010;
        3'd2:    return 5'b00100;
        3'd3:    return 5'b01000;
        3'd4:    return 5'b10000;
        default: return 5'b00000;
    endcase
endfunction

// Config cycles carry only the register number
function automatic addrT expectAddr(input addrT a);
    if (a[31:28] == 4'hC) begin
        return a & 32'h0000_07fc;
    end
    return a;
endfunction

////////////////////
// Failure and compares
////////////////////

task automatic failRun();
    $display("TESTS FAILED");
    $fatal(1, "run stopped on first error");
endtask

task automatic timeoutFail(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    failRun();
endtask

task automatic checkData(input string name, input dataT got, input dataT exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        failRun();
    end
endtask

task automatic checkCmd(input string name, input pciCmdT got, input pciCmdT exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        failRun();
    end
endtask

task automatic checkIdsel(input string name, input idselT got, input idselT exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
        failRun();
    end
endtask

// Single control lines
task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
        failRun();
    end
endtask

`endif

/* sim/pciBridgeTb.sv */
// PCI bridge testbench
// CPU stimulus, PCI target model and checks
`timescale 1ns/1ps

module pciBridgeTb;
    import bridgePkg::*;

    localparam int waitLimit = 400;

    logic   CLK40;
    logic   rstN;
    logic   cpuValid;
    logic   cpuRnW;
    addrT   cpuAddr;
    dataT   cpuWrData;
    logic   trdyN;
    logic   devselN;
    dataT   adIn;
    logic   cpuReady;
    logic   cpuRspValid;
    dataT   cpuRdData;
    logic   frameN;
    logic   irdyN;
    pciCmdT cbeN;
    dataT   adOut;
    logic   adOe;
    idselT  idsel;

    // Target storage and transaction log
    dataT   memWords [addrT];
    dataT   cfgWords [int];
    pciCmdT recCmd [$];
    idselT  recIdsel [$];
    addrT   recAddr [$];
    dataT   recData [$];
    pciCmdT tgtCmd;
    addrT   tgtAddr;
    idselT  tgtIdsel;
    logic   tgtClaim;
    int     tgtDelay;
    int     tgtWait;
    int     stallCycles;
    int     ackCount;
    int     maxLowRun;

    `include "bridgeCheck.svh"

    pciBridgeTop pciBridgeTop_i (.*);

    initial begin
        CLK40 = 1'b0;
    end

    always #20 CLK40 = ~CLK40;

    ////////////////////
    // PCI target model
    ////////////////////

    function automatic int cfgKey(input idselT sel, input addrT a);
        cfgKey = int'({sel, a[10:0]});
    endfunction

    // Word the target returns, PCI byte order
    function automatic dataT readWord();
        if (tgtCmd == 4'h6) begin
            return memWords.exists(tgtAddr) ? memWords[tgtAddr] : '0;
        end
        if (cfgWords.exists(cfgKey(tgtIdsel, tgtAddr))) begin
            return cfgWords[cfgKey(tgtIdsel, tgtAddr)];
        end
        return '0;
    endfunction

    // Claims memory space and any selected slot
    always @(posedge CLK40) begin
        if (!rstN) begin
            devselN <= 1'b1;
            trdyN   <= 1'b1;
        end else if (!frameN) begin
            // Address goes out on AD
            checkBit("adOe in address phase", adOe, 1'b1);
            tgtCmd   = cbeN;
            tgtAddr  = adOut;
            tgtIdsel = idsel;
            tgtClaim = (cbeN == 4'h6) || (cbeN == 4'h7) || (idsel != '0);
            tgtDelay = $urandom % 3;
            tgtWait  = 0;
            recCmd.push_back(cbeN);
            recIdsel.push_back(idsel);
            recAddr.push_back(adOut);
        end else if (!irdyN && !trdyN) begin
            // Master drives AD only on writes
            checkBit("adOe in data phase", adOe, (tgtCmd == 4'h7) || (tgtCmd == 4'hB));
            // Data moves on this edge
            if (tgtCmd == 4'h7) begin
                memWords[tgtAddr] = adOut;
                recData.push_back(adOut);
            end else if (tgtCmd == 4'hB) begin
                cfgWords[cfgKey(tgtIdsel, tgtAddr)] = adOut;
                recData.push_back(adOut);
            end
            devselN <= 1'b1;
            trdyN   <= 1'b1;
        end else if (!irdyN && tgtClaim) begin
            if (tgtWait == tgtDelay) begin
                devselN <= 1'b0;
            end
            // Slow target holds TRDY back after DEVSEL
            if (tgtWait == tgtDelay + stallCycles) begin
                trdyN <= 1'b0;
                adIn  <= readWord();
            end
            tgtWait = tgtWait + 1;
        end
    end

    // Acknowledge counter
    always @(posedge CLK40) begin
        if (rstN && cpuRspValid) begin
            ackCount <= ackCount + 1;
        end
    end

    ////////////////////
    // CPU side tasks
    ////////////////////

    task automatic clearRecords();
        recCmd.delete();
        recIdsel.delete();
        recAddr.delete();
        recData.delete();
    endtask

    // Posted write, ack due one cycle after acceptance
    task automatic cpuWrite(input addrT a, input dataT d);
        int   lowRun;
        logic accepted;
        cpuValid  <= 1'b1;
        cpuRnW    <= 1'b0;
        cpuAddr   <= a;
        cpuWrData <= d;
        lowRun   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge CLK40);
            if (cpuReady) begin
                accepted = 1'b1;
            end else begin
                lowRun = lowRun + 1;
                if (lowRun > maxLowRun) begin
                    maxLowRun = lowRun;
                end
                if (lowRun > waitLimit) begin
                    timeoutFail("cpuReady on a write");
                end
            end
        end
        cpuValid <= 1'b0;
        @(posedge CLK40);
        checkBit("cpuRspValid", cpuRspValid, 1'b1);
    endtask

    // Read, with cpuReady low until the response
    task automatic cpuRead(input addrT a, output dataT d);
        int   n;
        logic accepted;
        logic done;
        cpuValid <= 1'b1;
        cpuRnW   <= 1'b1;
        cpuAddr  <= a;
        n        = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge CLK40);
            if (cpuReady) begin
                accepted = 1'b1;
            end else begin
                n = n + 1;
                if (n > waitLimit) begin
                    timeoutFail("cpuReady on a read");
                end
            end
        end
        cpuValid <= 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge CLK40);
            if (cpuRspValid) begin
                done = 1'b1;
            end else begin
                checkBit("cpuReady", cpuReady, 1'b0);
                n = n + 1;
                if (n > waitLimit) begin
                    timeoutFail("a read response");
                end
            end
        end
        d = cpuRdData;
    endtask

    task automatic waitWrites(input int count);
        int n;
        n = 0;
        while (recData.size() < count) begin
            @(posedge CLK40);
            n = n + 1;
            if (n > waitLimit * 4) begin
                timeoutFail("posted writes at the target");
            end
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        dataT rd;
        dataT wd [8];
        addrT a;
        int   acksBefore;
        void'($urandom(32'h814b));
        cpuValid    = 1'b0;
        cpuRnW      = 1'b0;
        cpuAddr     = '0;
        cpuWrData   = '0;
        trdyN       = 1'b1;
        devselN     = 1'b1;
        adIn        = '0;
        rstN        = 1'b0;
        stallCycles = 0;
        ackCount    = 0;
        maxLowRun   = 0;
        repeat (2) @(posedge CLK40);
        rstN <= 1'b1;
        @(posedge CLK40);

        // Idle bus after reset
        checkBit("frameN", frameN, 1'b1);
        checkBit("irdyN", irdyN, 1'b1);
        checkBit("adOe", adOe, 1'b0);
        checkIdsel("idsel", idsel, 5'b00000);
        checkBit("cpuRspValid", cpuRspValid, 1'b0);
        checkBit("cpuReady", cpuReady, 1'b1);

        // Memory write and read back
        clearRecords();
        a     = 32'h4000_0000 | ($urandom & 32'h00ff_fffc);
        wd[0] = $urandom;
        cpuWrite(a, wd[0]);
        cpuRead(a, rd);
        checkData("cpuRdData", rd, wd[0]);
        checkCmd("write cbeN", recCmd[0], expectCmd(1'b0, a));
        checkCmd("read cbeN", recCmd[1], expectCmd(1'b1, a));
        checkData("write adOut", recData[0], swapBytes(wd[0]));
        checkData("write address", recAddr[0], expectAddr(a));
        checkData("read address", recAddr[1], expectAddr(a));

        // Config slots, populated and empty
        for (int s = 0; s < 8; s++) begin
            clearRecords();
            a     = {4'hC, 14'($urandom), 3'(s), 9'($urandom), 2'b00};
            wd[0] = $urandom;
            cpuWrite(a, wd[0]);
            cpuRead(a, rd);
            checkCmd("config write cbeN", recCmd[0], expectCmd(1'b0, a));
            checkCmd("config read cbeN", recCmd[1], expectCmd(1'b1, a));
            checkIdsel("config write idsel", recIdsel[0], expectIdsel(a));
            checkIdsel("config read idsel", recIdsel[1], expectIdsel(a));
            checkData("config write address", recAddr[0], expectAddr(a));
            checkData("config read address", recAddr[1], expectAddr(a));
            if (s < 5) begin
                checkData("config readback", rd, wd[0]);
            end else begin
                // Master abort
                checkBit("write claimed", recData.size() != 0, 1'b0);
                checkData("aborted read", rd, 32'hFFFF_FFFF);
            end
        end

        // Posted writes into a stalled target
        clearRecords();
        // Let the last read's ack land in the counter
        @(posedge CLK40);
        stallCycles = 6;
        maxLowRun   = 0;
        acksBefore  = ackCount;
        a           = 32'h2000_0100;
        for (int i = 0; i < 8; i++) begin
            wd[i] = $urandom;
            cpuWrite(a + 32'(4 * i), wd[i]);
        end
        waitWrites(8);
        checkData("ack count", dataT'(ackCount - acksBefore), 32'd8);
        checkBit("cpuReady low on full FIFO", maxLowRun >= 3, 1'b1);
        for (int i = 0; i < 8; i++) begin
            checkData("posted write data", recData[i], swapBytes(wd[i]));
            checkData("posted write address", recAddr[i], a + 32'(4 * i));
        end

        // Last posted value wins
        clearRecords();
        stallCycles = 2;
        a           = 32'h2000_0800;
        for (int i = 0; i < 3; i++) begin
            wd[i] = $urandom;
            cpuWrite(a, wd[i]);
        end
        cpuRead(a, rd);
        checkData("read after posted writes", rd, wd[2]);

        $display("TESTS PASSED");
        $finish;
    end

endmodule
